// File: design/pxie_rx_defines.svh
`ifndef PXIE_RX_DEFINES_SVH
`define PXIE_RX_DEFINES_SVH

// Header codes in word bits 127..112
`define PXIE_HDR_CMD        16'heb9c
`define PXIE_HDR_ISA        16'heb00
`define PXIE_HDR_SYS        16'heb01
`define PXIE_HDR_C2H        16'heb02

// Start codes, in the low 16 bits of a command word
`define PXIE_CODE_RST       16'h0001
`define PXIE_CODE_TRIG      16'h0002
`define PXIE_CODE_ISA       16'h1000
`define PXIE_CODE_SYS       16'h1001
`define PXIE_CODE_READCFG   16'h1010

// Config selectors, in bits 111..96
`define PXIE_CFG_TRIG_NUM   16'h0003
`define PXIE_CFG_TRIG_STEP  16'h0004

// Field positions inside a link word
`define PXIE_FLD_HDR        127:112
`define PXIE_FLD_SEL        111:96
`define PXIE_FLD_CODE       15:0
`define PXIE_FLD_VALUE      31:0
`define PXIE_FLD_C2H_ADDR   15:0
`define PXIE_FLD_C2H_LEN    31:16

// Cycles a reset or trigger command keeps the receiver busy
`define PXIE_HOLD_CYCLES    50

`endif

// File: design/pxie_rx_pkg.sv
`default_nettype none

package pxie_rx_pkg;

	// Plain widths of the link
	typedef logic [127:0] pxie_word_t;
	typedef logic [31:0]  ram_addr_t;
	typedef logic [15:0]  burst_cnt_t;
	typedef logic [31:0]  cfg_word_t;
	typedef logic [15:0]  c2h_field_t;
	typedef logic [5:0]   hold_cnt_t;

	// One strobe per recognized command, at most one high
	typedef struct packed {
		logic start_rst;
		logic start_trig;
		logic start_isa;
		logic start_sys;
		logic start_readcfg;
		logic load_trig_num;
		logic load_trig_step;
		logic load_isa;
		logic load_sys;
		logic load_c2h;
	} cmd_strobe_t;

	// RAM write port
	typedef struct packed {
		logic       wren;
		ram_addr_t  addr;
		pxie_word_t data;
	} ram_wr_t;

	typedef struct packed {
		cfg_word_t trig_num;
		cfg_word_t trig_step;
	} trig_cfg_t;

	typedef struct packed {
		c2h_field_t addr;
		c2h_field_t len;
	} c2h_cfg_t;

	typedef enum logic [2:0] {
		ST_HEAD,
		ST_RST,
		ST_TRIG,
		ST_ISA,
		ST_SYS,
		ST_READCFG,
		ST_DONE
	} rx_state_t;

endpackage

`default_nettype wire

// File: design/pxie_cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "pxie_rx_defines.svh"

module pxie_cmd_decoder
	import pxie_rx_pkg::*;
(
	input  wire pxie_word_t  data,
	input  wire logic        data_vld,
	input  wire logic        hdr_en,
	output cmd_strobe_t      cmd
);

	logic [15:0] hdr_field;
	logic [15:0] code_field;
	logic [15:0] sel_field;

	assign hdr_field  = data[`PXIE_FLD_HDR];
	assign code_field = data[`PXIE_FLD_CODE];
	assign sel_field  = data[`PXIE_FLD_SEL];

	////////////////////////////////////////////////////////////////////////////
	// Word classification
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		cmd = '0;
		if (data_vld && hdr_en)
		begin
			if (hdr_field == `PXIE_HDR_CMD)
			begin
				// Start codes win over config selectors
				case (code_field)
					`PXIE_CODE_RST:     cmd.start_rst     = 1'b1;
					`PXIE_CODE_TRIG:    cmd.start_trig    = 1'b1;
					`PXIE_CODE_ISA:     cmd.start_isa     = 1'b1;
					`PXIE_CODE_SYS:     cmd.start_sys     = 1'b1;
					`PXIE_CODE_READCFG: cmd.start_readcfg = 1'b1;
					default:
					begin
						if (sel_field == `PXIE_CFG_TRIG_NUM)
							cmd.load_trig_num = 1'b1;
						else if (sel_field == `PXIE_CFG_TRIG_STEP)
							cmd.load_trig_step = 1'b1;
					end
				endcase
			end
			else if (hdr_field == `PXIE_HDR_ISA)
			begin
				cmd.load_isa = 1'b1;
			end
			else if (hdr_field == `PXIE_HDR_SYS)
			begin
				cmd.load_sys = 1'b1;
			end
			else if (hdr_field == `PXIE_HDR_C2H)
			begin
				cmd.load_c2h = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: design/pxie_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "pxie_rx_defines.svh"

module pxie_cfg_regs
	import pxie_rx_pkg::*;
(
	input  wire logic        I_PXIE_CLK,
	input  wire logic        I_Rst_n,
	input  wire pxie_word_t  data,
	input  wire cmd_strobe_t cmd,
	output trig_cfg_t        trig_cfg,
	output c2h_cfg_t         c2h_cfg
);

	////////////////////////////////////////////////////////////////////////////
	// Trigger configuration
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge I_PXIE_CLK or negedge I_Rst_n)
	begin
		if (!I_Rst_n)
		begin
			trig_cfg <= '0;
		end
		else
		begin
			if (cmd.load_trig_num)
			begin
				trig_cfg.trig_num <= data[`PXIE_FLD_VALUE];
			end
			// Step written separately by its own selector
			if (cmd.load_trig_step)
			begin
				trig_cfg.trig_step <= data[`PXIE_FLD_VALUE];
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Card-to-host transfer window
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge I_PXIE_CLK or negedge I_Rst_n)
	begin
		if (!I_Rst_n)
		begin
			c2h_cfg <= '0;
		end
		else if (cmd.load_c2h)
		begin
			// Address in the low half, length above it
			c2h_cfg.addr <= data[`PXIE_FLD_C2H_ADDR];
			c2h_cfg.len  <= data[`PXIE_FLD_C2H_LEN];
		end
	end

endmodule

`default_nettype wire

// File: design/pxie_burst_writer.sv
`timescale 1ns/1ps
`default_nettype none

`include "pxie_rx_defines.svh"

module pxie_burst_writer
	import pxie_rx_pkg::*;
(
	input  wire logic        I_PXIE_CLK,
	input  wire logic        I_Rst_n,
	input  wire logic        load,
	input  wire logic        active,
	input  wire pxie_word_t  data,
	input  wire logic        data_vld,
	output ram_wr_t          wr,
	output logic             done
);

	ram_addr_t  cur_addr;
	burst_cnt_t word_num;
	burst_cnt_t wr_cnt;
	logic       wr_take;

	// Burst is complete once every announced word is written
	assign done = (wr_cnt == word_num);

	// No writes beyond the loaded count
	assign wr_take = active && data_vld && !done;

	////////////////////////////////////////////////////////////////////////////
	// Base address and count
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge I_PXIE_CLK or negedge I_Rst_n)
	begin
		if (!I_Rst_n)
		begin
			cur_addr <= '0;
			word_num <= '0;
		end
		else if (load)
		begin
			cur_addr <= data[`PXIE_FLD_VALUE];
			word_num <= data[`PXIE_FLD_SEL];
		end
		else if (wr_take)
		begin
			cur_addr <= cur_addr + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Write port and written count
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge I_PXIE_CLK or negedge I_Rst_n)
	begin
		if (!I_Rst_n)
		begin
			wr     <= '0;
			wr_cnt <= '0;
		end
		else
		begin
			if (wr_take)
			begin
				wr.wren <= 1'b1;
				wr.addr <= cur_addr;
				wr.data <= data;
				wr_cnt  <= wr_cnt + 1'b1;
			end
			else
			begin
				// Address held, data parked at zero between writes
				wr.wren <= 1'b0;
				wr.data <= '0;
				if (!active)
					wr_cnt <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// File: design/pxie_rx_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "pxie_rx_defines.svh"

module pxie_rx_fsm
	import pxie_rx_pkg::*;
(
	input  wire logic        I_PXIE_CLK,
	input  wire logic        I_Rst_n,
	input  wire cmd_strobe_t cmd,
	input  wire logic        isa_done,
	input  wire logic        sys_done,
	output logic             hdr_en,
	output logic             isa_active,
	output logic             sys_active,
	output logic             soft_rst,
	output logic             trig,
	output logic             c2h_en,
	output logic             rx_busy
);

	rx_state_t state;
	rx_state_t next_state;
	hold_cnt_t hold_cnt;
	logic      hold_state;
	logic      hold_last;

	assign hold_state = (state == ST_RST) || (state == ST_TRIG);
	assign hold_last  = (hold_cnt == hold_cnt_t'(`PXIE_HOLD_CYCLES));

	////////////////////////////////////////////////////////////////////////////
	// State register and next state
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge I_PXIE_CLK or negedge I_Rst_n)
	begin
		if (!I_Rst_n)
			state <= ST_HEAD;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state;
		case (state)
			ST_HEAD:
			begin
				if (cmd.start_rst)
					next_state = ST_RST;
				else if (cmd.start_trig)
					next_state = ST_TRIG;
				else if (cmd.start_isa)
					next_state = ST_ISA;
				else if (cmd.start_sys)
					next_state = ST_SYS;
				else if (cmd.start_readcfg)
					next_state = ST_READCFG;
			end
			ST_RST, ST_TRIG:
			begin
				if (hold_last)
					next_state = ST_DONE;
			end
			ST_ISA:
			begin
				if (isa_done)
					next_state = ST_DONE;
			end
			ST_SYS:
			begin
				if (sys_done)
					next_state = ST_DONE;
			end
			ST_READCFG: next_state = ST_DONE;
			ST_DONE:    next_state = ST_HEAD;
			default:    next_state = ST_HEAD;
		endcase
	end

	// Counts 0 to PXIE_HOLD_CYCLES while holding
	always_ff @(posedge I_PXIE_CLK or negedge I_Rst_n)
	begin
		if (!I_Rst_n)
			hold_cnt <= '0;
		else if (hold_state && !hold_last)
			hold_cnt <= hold_cnt + 1'b1;
		else
			hold_cnt <= '0;
	end

	////////////////////////////////////////////////////////////////////////////
	// Outputs
	////////////////////////////////////////////////////////////////////////////

	// Strobes only fire in ST_HEAD, so each pulse lasts one cycle
	always_ff @(posedge I_PXIE_CLK or negedge I_Rst_n)
	begin
		if (!I_Rst_n)
		begin
			soft_rst <= 1'b0;
			trig     <= 1'b0;
			c2h_en   <= 1'b0;
		end
		else
		begin
			soft_rst <= cmd.start_rst;
			trig     <= cmd.start_trig;
			c2h_en   <= cmd.start_readcfg;
		end
	end

	assign hdr_en     = (state == ST_HEAD);
	assign rx_busy    = (state != ST_HEAD);
	assign isa_active = (state == ST_ISA);
	assign sys_active = (state == ST_SYS);

endmodule

`default_nettype wire

// File: design/pxie_rx_data.sv
`timescale 1ns/1ps
`default_nettype none

module pxie_rx_data
	import pxie_rx_pkg::*;
(
	input  wire logic        I_PXIE_CLK,
	input  wire logic        I_Rst_n,
	input  wire pxie_word_t  data,
	input  wire logic        data_vld,
	output ram_wr_t          isa_wr,
	output ram_wr_t          sys_wr,
	output trig_cfg_t        trig_cfg,
	output c2h_cfg_t         c2h_cfg,
	output logic             soft_rst,
	output logic             trig,
	output logic             c2h_en,
	output logic             rx_busy
);

	cmd_strobe_t cmd;
	logic        hdr_en;
	logic        isa_active;
	logic        sys_active;
	logic        isa_done;
	logic        sys_done;

	////////////////////////////////////////////////////////////////////////////
	// Command path
	////////////////////////////////////////////////////////////////////////////

	pxie_cmd_decoder u_decoder (
		.data     (data),
		.data_vld (data_vld),
		.hdr_en   (hdr_en),
		.cmd      (cmd)
	);

	pxie_cfg_regs u_cfg_regs (
		.I_PXIE_CLK (I_PXIE_CLK),
		.I_Rst_n    (I_Rst_n),
		.data       (data),
		.cmd        (cmd),
		.trig_cfg   (trig_cfg),
		.c2h_cfg    (c2h_cfg)
	);

	pxie_rx_fsm u_fsm (
		.I_PXIE_CLK (I_PXIE_CLK),
		.I_Rst_n    (I_Rst_n),
		.cmd        (cmd),
		.isa_done   (isa_done),
		.sys_done   (sys_done),
		.hdr_en     (hdr_en),
		.isa_active (isa_active),
		.sys_active (sys_active),
		.soft_rst   (soft_rst),
		.trig       (trig),
		.c2h_en     (c2h_en),
		.rx_busy    (rx_busy)
	);

	////////////////////////////////////////////////////////////////////////////
	// RAM burst channels
	////////////////////////////////////////////////////////////////////////////

	// Instruction RAM
	pxie_burst_writer u_isa_writer (
		.I_PXIE_CLK (I_PXIE_CLK),
		.I_Rst_n    (I_Rst_n),
		.load       (cmd.load_isa),
		.active     (isa_active),
		.data       (data),
		.data_vld   (data_vld),
		.wr         (isa_wr),
		.done       (isa_done)
	);

	// System RAM
	pxie_burst_writer u_sys_writer (
		.I_PXIE_CLK (I_PXIE_CLK),
		.I_Rst_n    (I_Rst_n),
		.load       (cmd.load_sys),
		.active     (sys_active),
		.data       (data),
		.data_vld   (data_vld),
		.wr         (sys_wr),
		.done       (sys_done)
	);

endmodule

`default_nettype wire

// File: testbench/tb_pxie_rx_data.sv
`timescale 1ns/1ps
`default_nettype none

`include "pxie_rx_defines.svh"

module tb_pxie_rx_data
	import pxie_rx_pkg::*;
();

	logic         I_PXIE_CLK;
	logic         I_Rst_n;
	pxie_word_t   data;
	logic         data_vld;
	ram_wr_t      isa_wr;
	ram_wr_t      sys_wr;
	trig_cfg_t    trig_cfg;
	c2h_cfg_t     c2h_cfg;
	logic         soft_rst;
	logic         trig;
	logic         c2h_en;
	logic         rx_busy;

	logic [31:0]  lfsr;
	int           errors;
	int           timeouts;
	int           isa_writes;
	int           sys_writes;
	int           rst_pulses;
	int           trig_pulses;
	int           c2h_pulses;
	int           busy_cycles;
	trig_cfg_t    exp_trig;
	c2h_cfg_t     exp_c2h;
	cfg_word_t    val;
	// Expected writes as {sys channel, address, word}
	logic [160:0] exp_q[$];
	logic [160:0] got_wr;
	logic [160:0] exp_wr;

	pxie_rx_data UUT (
		.I_PXIE_CLK (I_PXIE_CLK),
		.I_Rst_n    (I_Rst_n),
		.data       (data),
		.data_vld   (data_vld),
		.isa_wr     (isa_wr),
		.sys_wr     (sys_wr),
		.trig_cfg   (trig_cfg),
		.c2h_cfg    (c2h_cfg),
		.soft_rst   (soft_rst),
		.trig       (trig),
		.c2h_en     (c2h_en),
		.rx_busy    (rx_busy)
	);

	always #2 I_PXIE_CLK = ~I_PXIE_CLK;

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] bits;
		logic        fb;
		int          i;
		bits = '0;
		for (i = 0; i < n; i++)
		begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			bits = {bits[30:0], fb};
		end
		return bits;
	endfunction

	function automatic pxie_word_t rand_word();
		return {take_bits(32), take_bits(32), take_bits(32), take_bits(32)};
	endfunction

	function automatic pxie_word_t start_word(input logic [15:0] code);
		return {`PXIE_HDR_CMD, 96'h0, code};
	endfunction

	function automatic pxie_word_t cfg_word(input logic [15:0] sel, input cfg_word_t value);
		return {`PXIE_HDR_CMD, sel, 64'h0, value};
	endfunction

	function automatic pxie_word_t load_word(input logic [15:0] hdr, input burst_cnt_t cnt,
		input ram_addr_t base);
		return {hdr, cnt, 64'h0, base};
	endfunction

	function automatic pxie_word_t c2h_word(input c2h_field_t addr, input c2h_field_t len);
		return {`PXIE_HDR_C2H, 16'h0, 64'h0, len, addr};
	endfunction

	task automatic drive(input pxie_word_t word, input logic vld);
		@(negedge I_PXIE_CLK);
		data     = word;
		data_vld = vld;
	endtask

	task automatic clear_counts();
		isa_writes  = 0;
		sys_writes  = 0;
		rst_pulses  = 0;
		trig_pulses = 0;
		c2h_pulses  = 0;
		busy_cycles = 0;
	endtask

	task automatic wait_idle(input int limit);
		int n;
		n = 0;
		@(negedge I_PXIE_CLK);
		while (rx_busy && n < limit)
		begin
			@(negedge I_PXIE_CLK);
			n++;
		end
		if (rx_busy)
		begin
			$display("Timeout: rx_busy still high after %0d cycles", limit);
			timeouts++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [159:0] exp_val,
		input logic [159:0] act_val);
		assert (act_val === exp_val)
		else
		begin
			$display("[ERROR] %s expected %h got %h", name, exp_val, act_val);
			errors++;
		end
	endtask

	task automatic check_cfg();
		check_value("trig_cfg.trig_num", exp_trig.trig_num, trig_cfg.trig_num);
		check_value("trig_cfg.trig_step", exp_trig.trig_step, trig_cfg.trig_step);
		check_value("c2h_cfg.addr", exp_c2h.addr, c2h_cfg.addr);
		check_value("c2h_cfg.len", exp_c2h.len, c2h_cfg.len);
	endtask

	task automatic check_pulses(input int n_rst, input int n_trig, input int n_c2h,
		input int n_busy);
		check_value("soft_rst cycles", n_rst, rst_pulses);
		check_value("trig cycles", n_trig, trig_pulses);
		check_value("c2h_en cycles", n_c2h, c2h_pulses);
		check_value("rx_busy cycles", n_busy, busy_cycles);
	endtask

	task automatic run_pulse_cmd(input logic [15:0] code, input int n_rst, input int n_trig,
		input int n_c2h, input int n_busy);
		clear_counts();
		drive(start_word(code), 1'b1);
		drive('0, 1'b0);
		wait_idle(200);
		check_pulses(n_rst, n_trig, n_c2h, n_busy);
	endtask

	task automatic run_burst(input logic to_sys, input int count);
		ram_addr_t  base;
		pxie_word_t word;
		int         gap;
		int         i;
		clear_counts();
		base = take_bits(32);
		drive(load_word(to_sys ? `PXIE_HDR_SYS : `PXIE_HDR_ISA, burst_cnt_t'(count), base), 1'b1);
		drive(start_word(to_sys ? `PXIE_CODE_SYS : `PXIE_CODE_ISA), 1'b1);
		for (i = 0; i < count; i++)
		begin
			// Idle gaps carry junk with valid low
			gap = take_bits(2);
			repeat (gap) drive(rand_word(), 1'b0);
			word = rand_word();
			exp_q.push_back({to_sys, ram_addr_t'(base + ram_addr_t'(i)), word});
			drive(word, 1'b1);
		end
		drive('0, 1'b0);
		wait_idle(200);
		check_value("isa write count", to_sys ? 0 : count, isa_writes);
		check_value("sys write count", to_sys ? count : 0, sys_writes);
		check_value("writes left in queue", 0, exp_q.size());
	endtask

	// Pulse, busy and RAM write monitor
	always @(negedge I_PXIE_CLK)
	begin
		if (I_Rst_n)
		begin
			rst_pulses  += soft_rst;
			trig_pulses += trig;
			c2h_pulses  += c2h_en;
			busy_cycles += rx_busy;
			if (isa_wr.wren || sys_wr.wren)
			begin
				if (sys_wr.wren)
					sys_writes++;
				else
					isa_writes++;
				got_wr = sys_wr.wren ? {1'b1, sys_wr.addr, sys_wr.data}
					: {1'b0, isa_wr.addr, isa_wr.data};
				assert (exp_q.size() > 0)
				else
				begin
					$display("RAM write seen with no word expected");
					errors++;
				end
				if (exp_q.size() > 0)
				begin
					exp_wr = exp_q.pop_front();
					check_value("write channel", exp_wr[160], got_wr[160]);
					check_value("wr.addr", exp_wr[159:128], got_wr[159:128]);
					check_value("wr.data", exp_wr[127:0], got_wr[127:0]);
				end
			end
		end
	end

	pulses_exclusive: assert property (@(posedge I_PXIE_CLK) disable iff (!I_Rst_n)
		$onehot0({soft_rst, trig, c2h_en}))
	else
	begin
		$display("More than one control pulse high in the same cycle");
		errors++;
	end

	writes_exclusive: assert property (@(posedge I_PXIE_CLK) disable iff (!I_Rst_n)
		!(isa_wr.wren && sys_wr.wren))
	else
	begin
		$display("Both RAM channels wrote in the same cycle");
		errors++;
	end

	write_while_busy: assert property (@(posedge I_PXIE_CLK) disable iff (!I_Rst_n)
		(isa_wr.wren || sys_wr.wren) |-> rx_busy)
	else
	begin
		$display("RAM write while the receiver was idle");
		errors++;
	end

	data_parked: assert property (@(posedge I_PXIE_CLK) disable iff (!I_Rst_n)
		(isa_wr.wren || isa_wr.data == '0) && (sys_wr.wren || sys_wr.data == '0))
	else
	begin
		$display("RAM write data not zero while wren is low");
		errors++;
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		I_PXIE_CLK = 1'b0;
		I_Rst_n    = 1'b0;
		data       = '0;
		data_vld   = 1'b0;
		lfsr       = 32'h23bf_8e86;
		errors     = 0;
		timeouts   = 0;
		exp_trig   = '0;
		exp_c2h    = '0;
		clear_counts();
		repeat (2) @(negedge I_PXIE_CLK);
		I_Rst_n = 1'b1;

		// Idle and cleared after reset
		check_value("soft_rst", 0, soft_rst);
		check_value("trig", 0, trig);
		check_value("c2h_en", 0, c2h_en);
		check_value("rx_busy", 0, rx_busy);
		check_value("isa_wr.wren", 0, isa_wr.wren);
		check_value("sys_wr.wren", 0, sys_wr.wren);
		check_cfg();

		// Bit 15 set keeps the value clear of every start code
		val = take_bits(32) | 32'h8000;
		exp_trig.trig_num = val;
		drive(cfg_word(`PXIE_CFG_TRIG_NUM, val), 1'b1);
		val = take_bits(32) | 32'h8000;
		exp_trig.trig_step = val;
		drive(cfg_word(`PXIE_CFG_TRIG_STEP, val), 1'b1);
		drive('0, 1'b0);
		check_cfg();
		run_pulse_cmd(`PXIE_CODE_TRIG, 0, 1, 0, `PXIE_HOLD_CYCLES + 2);
		run_pulse_cmd(`PXIE_CODE_RST, 1, 0, 0, `PXIE_HOLD_CYCLES + 2);

		repeat (3)
		begin
			run_burst(1'b0, take_bits(4) + 1);
			run_burst(1'b1, take_bits(4) + 1);
		end
		run_burst(1'b1, 0);

		exp_c2h.addr = c2h_field_t'(take_bits(16));
		exp_c2h.len  = c2h_field_t'(take_bits(16));
		drive(c2h_word(exp_c2h.addr, exp_c2h.len), 1'b1);
		drive('0, 1'b0);
		check_cfg();
		run_pulse_cmd(`PXIE_CODE_READCFG, 0, 0, 1, 2);

		// Commands during a trigger hold are dropped
		clear_counts();
		drive(start_word(`PXIE_CODE_TRIG), 1'b1);
		drive(cfg_word(`PXIE_CFG_TRIG_NUM, take_bits(32) | 32'h8000), 1'b1);
		drive(c2h_word(c2h_field_t'(take_bits(16)), c2h_field_t'(take_bits(16))), 1'b1);
		drive(start_word(`PXIE_CODE_RST), 1'b1);
		drive(start_word(`PXIE_CODE_READCFG), 1'b1);
		drive('0, 1'b0);
		wait_idle(200);
		check_pulses(0, 1, 0, `PXIE_HOLD_CYCLES + 2);
		check_cfg();

		// Unknown header, then unknown code and selector
		clear_counts();
		drive({16'h1234, 96'h0, `PXIE_CODE_RST}, 1'b1);
		drive({`PXIE_HDR_CMD, 16'h7777, 64'h0, 32'h0000_5555}, 1'b1);
		repeat (4) drive('0, 1'b0);
		check_pulses(0, 0, 0, 0);
		check_cfg();

		$display("Summary: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+design
design/pxie_rx_pkg.sv
design/pxie_cmd_decoder.sv
design/pxie_cfg_regs.sv
design/pxie_burst_writer.sv
design/pxie_rx_fsm.sv
design/pxie_rx_data.sv
testbench/tb_pxie_rx_data.sv

// File: Bender.yml
package:
  name: pxie_rx_data

sources:
  - include_dirs:
      - design
    files:
      - design/pxie_rx_pkg.sv
      - design/pxie_cmd_decoder.sv
      - design/pxie_cfg_regs.sv
      - design/pxie_burst_writer.sv
      - design/pxie_rx_fsm.sv
      - design/pxie_rx_data.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/tb_pxie_rx_data.sv
